//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= simd_lane_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
RUNFLAGS  ?= +verilator+error+limit+100000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/functional_unit.sv
// Lane functional unit
module functional_unit #(
    parameter int LANE_ID = 0
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  simd_pkg::lane_instr_t issue_instr_i,
    input  simd_pkg::lane_instr_t sel_instr_i,
    output simd_pkg::bus64_t      data_vd_o
);
    import simd_pkg::*;

    bus64_t mul_b;
    bus64_t add_a;
    bus64_t add_b;
    bus64_t result_vaddsub;
    bus64_t result_vmul;
    bus64_t result_vcomp;
    bus64_t result_vshift;
    bus64_t vid_w [4];                       // Element indices per SEW

    // Multiplier takes old_vd instead of vs2 for VMADD and VNMSUB
    always_comb begin
        case (issue_instr_i.op)
            VMADD, VNMSUB: mul_b = issue_instr_i.old_vd;
            default:       mul_b = issue_instr_i.vs2;
        endcase
    end

    // Accumulate forms add the product to the other operand
    always_comb begin
        case (sel_instr_i.op)
            VMADD, VNMSUB: begin
                add_a = result_vmul;
                add_b = sel_instr_i.vs2;
            end
            VMACC, VNMSAC: begin
                add_a = result_vmul;
                add_b = sel_instr_i.old_vd;
            end
            default: begin
                add_a = sel_instr_i.vs1;
                add_b = sel_instr_i.vs2;
            end
        endcase
    end

    vmul vmul_inst (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .op_i   (issue_instr_i.op),
        .sew_i  (issue_instr_i.sew),
        .a_i    (issue_instr_i.vs1),
        .b_i    (mul_b),
        .prod_o (result_vmul)
    );

    vaddsub vaddsub_inst (
        .op_i  (sel_instr_i.op),
        .sew_i (sel_instr_i.sew),
        .a_i   (add_a),
        .b_i   (add_b),
        .sum_o (result_vaddsub)
    );

    vcomp vcomp_inst (
        .op_i  (sel_instr_i.op),
        .sew_i (sel_instr_i.sew),
        .a_i   (sel_instr_i.vs1),
        .b_i   (sel_instr_i.vs2),
        .res_o (result_vcomp)
    );

    vshift vshift_inst (
        .op_i  (sel_instr_i.op),
        .sew_i (sel_instr_i.sew),
        .a_i   (sel_instr_i.vs1),
        .b_i   (sel_instr_i.vs2),
        .res_o (result_vshift)
    );

    // Index of element j is LANE_ID times elements per lane plus j
    for (genvar g = 0; g < 4; g++) begin : g_vid
        localparam int W = 8 << g;
        localparam int N = XLEN / W;
        bus64_t idx;

        for (genvar j = 0; j < N; j++) begin : g_elem
            assign idx[j*W +: W] = W'(LANE_ID * N + j);
        end

        assign vid_w[g] = idx;
    end

    always_comb begin
        case (sel_instr_i.op)
            VADD, VSUB, VRSUB, VMACC, VNMSAC, VMADD, VNMSUB: data_vd_o = result_vaddsub;
            VMUL, VMULH, VMULHU:                             data_vd_o = result_vmul;
            VMIN, VMINU, VMAX, VMAXU:                        data_vd_o = result_vcomp;
            VMSEQ, VMSNE, VMSLT, VMSLTU:                     data_vd_o = result_vcomp;
            VSLL, VSRL, VSRA:                                data_vd_o = result_vshift;
            VAND: data_vd_o = sel_instr_i.vs1 & sel_instr_i.vs2;
            VOR:  data_vd_o = sel_instr_i.vs1 | sel_instr_i.vs2;
            VXOR: data_vd_o = sel_instr_i.vs1 ^ sel_instr_i.vs2;
            VMV:  data_vd_o = sel_instr_i.vs1;
            VID:  data_vd_o = vid_w[sel_instr_i.sew];
            default: data_vd_o = '0;
        endcase
    end

endmodule

//--- hdl/lane_issue.sv
// Lane instruction pipeline
module lane_issue (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  simd_pkg::lane_instr_t instr_i,
    output simd_pkg::lane_instr_t issue_o,
    output simd_pkg::lane_instr_t sel_o
);
    import simd_pkg::*;

    lane_instr_t issue_q;
    lane_instr_t sel_q;

    // Issue stage feeds the multiplier
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            issue_q <= '0;
        end else begin
            issue_q <= instr_i;
        end
    end

    // Select stage lines up with the registered product
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            sel_q <= '0;
        end else begin
            sel_q <= issue_q;
        end
    end

    assign issue_o = issue_q;
    assign sel_o   = sel_q;

endmodule

//--- hdl/simd_lane_top.sv
// SIMD lane top level
module simd_lane_top #(
    parameter int LANE_ID = 0
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  simd_pkg::lane_instr_t instr_i,
    output logic                  valid_o,
    output simd_pkg::bus64_t      data_vd_o
);
    import simd_pkg::*;

    lane_instr_t issue_instr;
    lane_instr_t sel_instr;

    lane_issue lane_issue_inst (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .instr_i (instr_i),
        .issue_o (issue_instr),
        .sel_o   (sel_instr)
    );

    functional_unit #(
        .LANE_ID (LANE_ID)
    ) functional_unit_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .issue_instr_i (issue_instr),
        .sel_instr_i   (sel_instr),
        .data_vd_o     (data_vd_o)
    );

    assign valid_o = sel_instr.valid;        // Result strobe two cycles after input

endmodule

//--- hdl/simd_pkg.sv
// SIMD lane shared types
package simd_pkg;

    localparam int XLEN = 64;                // Lane data width

    typedef logic [XLEN-1:0] bus64_t;

    // Selected element width
    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32,
        SEW_64
    } sew_t;

    // Lane opcodes
    typedef enum logic [4:0] {
        VADD,
        VSUB,                                // vs2 - vs1
        VRSUB,                               // vs1 - vs2
        VAND,
        VOR,
        VXOR,
        VMUL,
        VMULH,
        VMULHU,
        VMACC,                               // vd + vs1*vs2
        VNMSAC,                              // vd - vs1*vs2
        VMADD,                               // vs1*vd + vs2
        VNMSUB,                              // vs2 - vs1*vd
        VMIN,
        VMINU,
        VMAX,
        VMAXU,
        VMSEQ,
        VMSNE,
        VMSLT,
        VMSLTU,
        VSLL,
        VSRL,
        VSRA,
        VMV,
        VID
    } vop_t;

    // One lane instruction with its operands
    typedef struct packed {
        logic   valid;
        vop_t   op;
        sew_t   sew;
        bus64_t vs1;
        bus64_t vs2;
        bus64_t old_vd;                      // Accumulator for multiply-add
    } lane_instr_t;

endpackage

//--- hdl/vaddsub.sv
// Element-wise add and subtract
module vaddsub (
    input  simd_pkg::vop_t   op_i,
    input  simd_pkg::sew_t   sew_i,
    input  simd_pkg::bus64_t a_i,
    input  simd_pkg::bus64_t b_i,
    output simd_pkg::bus64_t sum_o
);
    import simd_pkg::*;

    bus64_t              x;
    bus64_t              y;
    logic                cin;
    logic [XLEN/8-1:0]   elem_start;         // Byte that opens an element

    // Subtraction as x + ~y + 1
    always_comb begin
        case (op_i)
            VSUB, VNMSAC, VNMSUB: begin
                x   = b_i;
                y   = ~a_i;
                cin = 1'b1;
            end
            VRSUB: begin
                x   = a_i;
                y   = ~b_i;
                cin = 1'b1;
            end
            default: begin
                x   = a_i;
                y   = b_i;
                cin = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (sew_i)
            SEW_8:   elem_start = 8'hFF;
            SEW_16:  elem_start = 8'h55;
            SEW_32:  elem_start = 8'h11;
            default: elem_start = 8'h01;
        endcase
    end

    // Byte-sliced adder whose chain restarts at each element
    always_comb begin
        logic       c;
        logic [8:0] s;
        c = cin;
        for (int i = 0; i < XLEN / 8; i++) begin
            if (elem_start[i]) begin
                c = cin;                     // Carry killed at boundary
            end
            s = {1'b0, x[8*i +: 8]} + {1'b0, y[8*i +: 8]} + {8'b0, c};
            sum_o[8*i +: 8] = s[7:0];
            c = s[8];
        end
    end

endmodule

//--- hdl/vcomp.sv
// Element-wise min, max and compares
module vcomp (
    input  simd_pkg::vop_t   op_i,
    input  simd_pkg::sew_t   sew_i,
    input  simd_pkg::bus64_t a_i,            // vs1
    input  simd_pkg::bus64_t b_i,            // vs2
    output simd_pkg::bus64_t res_o
);
    import simd_pkg::*;

    logic   signed_cmp;
    logic   is_min;
    logic   is_mask;                         // Compare gives packed bits
    bus64_t minmax_w [4];
    bus64_t mask_w [4];

    assign signed_cmp = (op_i == VMIN) || (op_i == VMAX) || (op_i == VMSLT);
    assign is_min     = (op_i == VMIN) || (op_i == VMINU);
    assign is_mask    = (op_i == VMSEQ) || (op_i == VMSNE) || (op_i == VMSLT) ||
                        (op_i == VMSLTU);

    for (genvar g = 0; g < 4; g++) begin : g_sew
        localparam int W = 8 << g;
        localparam int N = XLEN / W;
        bus64_t         mm;
        logic [N-1:0]   mask;

        for (genvar j = 0; j < N; j++) begin : g_elem
            logic [W-1:0] ea;
            logic [W-1:0] eb;
            logic         eq;
            logic         lt;                // vs2 below vs1

            assign ea = a_i[j*W +: W];
            assign eb = b_i[j*W +: W];
            assign eq = (ea == eb);
            assign lt = signed_cmp ? ($signed(eb) < $signed(ea)) : (eb < ea);
            assign mm[j*W +: W] = (is_min == lt) ? eb : ea;
            assign mask[j] = (op_i == VMSEQ) ? eq :
                             (op_i == VMSNE) ? !eq : lt;
        end

        assign minmax_w[g] = mm;
        assign mask_w[g]   = XLEN'(mask);    // Upper bits zero
    end

    assign res_o = is_mask ? mask_w[sew_i] : minmax_w[sew_i];

endmodule

//--- hdl/vmul.sv
// Element-wise multiplier
module vmul (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  simd_pkg::vop_t   op_i,
    input  simd_pkg::sew_t   sew_i,
    input  simd_pkg::bus64_t a_i,
    input  simd_pkg::bus64_t b_i,
    output simd_pkg::bus64_t prod_o
);
    import simd_pkg::*;

    logic   sgn;                             // Signed operands for VMULH
    logic   high;                            // Keep upper half
    bus64_t prod_w [4];                      // Packed result per SEW
    bus64_t prod_q;

    assign sgn  = (op_i == VMULH);
    assign high = (op_i == VMULH) || (op_i == VMULHU);

    for (genvar g = 0; g < 4; g++) begin : g_sew
        localparam int W = 8 << g;
        localparam int N = XLEN / W;
        bus64_t part;

        for (genvar j = 0; j < N; j++) begin : g_elem
            logic [W-1:0]   ea;
            logic [W-1:0]   eb;
            logic [2*W-1:0] full;            // Double-width product

            assign ea   = a_i[j*W +: W];
            assign eb   = b_i[j*W +: W];
            assign full = $signed({sgn & ea[W-1], ea}) * $signed({sgn & eb[W-1], eb});
            assign part[j*W +: W] = high ? full[2*W-1:W] : full[W-1:0];
        end

        assign prod_w[g] = part;
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            prod_q <= '0;
        end else begin
            prod_q <= prod_w[sew_i];
        end
    end

    assign prod_o = prod_q;

endmodule

//--- hdl/vshift.sv
// Element-wise shifter
module vshift (
    input  simd_pkg::vop_t   op_i,
    input  simd_pkg::sew_t   sew_i,
    input  simd_pkg::bus64_t a_i,            // Shift amounts
    input  simd_pkg::bus64_t b_i,            // Data
    output simd_pkg::bus64_t res_o
);
    import simd_pkg::*;

    bus64_t shift_w [4];

    for (genvar g = 0; g < 4; g++) begin : g_sew
        localparam int W  = 8 << g;
        localparam int N  = XLEN / W;
        localparam int SB = $clog2(W);
        bus64_t part;

        for (genvar j = 0; j < N; j++) begin : g_elem
            logic [SB-1:0] sh;               // Amount modulo SEW
            logic [W-1:0]  eb;

            assign sh = a_i[j*W +: SB];
            assign eb = b_i[j*W +: W];
            assign part[j*W +: W] = (op_i == VSLL) ? (eb << sh) :
                                    (op_i == VSRA) ? W'($signed(eb) >>> sh) :
                                                     (eb >> sh);
        end

        assign shift_w[g] = part;
    end

    assign res_o = shift_w[sew_i];

endmodule

//--- list.f
hdl/simd_pkg.sv
hdl/lane_issue.sv
hdl/vaddsub.sv
hdl/vmul.sv
hdl/vcomp.sv
hdl/vshift.sv
hdl/functional_unit.sv
hdl/simd_lane_top.sv
tests/simd_lane_chk.sv
tests/simd_lane_tb.sv

//--- tests/simd_lane_chk.sv
// SIMD lane result checker
module simd_lane_chk #(
    parameter int LANE_ID = 0
) (
    input logic                  clk_i,
    input logic                  rstn_i,
    input simd_pkg::lane_instr_t instr_i,
    input logic                  valid_i,
    input simd_pkg::bus64_t      data_i
);
    timeunit 1ns;
    timeprecision 100ps;

    import simd_pkg::*;

    int          err_cnt = 0;
    lane_instr_t instr_d1;
    lane_instr_t instr_d2;                   // Instruction now at the output
    bus64_t      expected;

    // Two-cycle history of the top port
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            instr_d1 <= '0;
            instr_d2 <= '0;
        end else begin
            instr_d1 <= instr_i;
            instr_d2 <= instr_d1;
        end
    end

    // Low w bits of v sign-extended to 128 bits
    function automatic logic [127:0] sext(bus64_t v, int w);
        logic [127:0] x;
        x = {64'd0, v} & ((128'd1 << w) - 128'd1);
        if (x[w-1]) begin
            x = x | ~((128'd1 << w) - 128'd1);
        end
        return x;
    endfunction

    function automatic bus64_t ref_result(lane_instr_t in);
        int           w;
        int           n;
        int           sh;
        logic [127:0] m;
        logic [127:0] a;
        logic [127:0] b;
        logic [127:0] d;
        logic [127:0] e;
        bus64_t       res;
        w   = 8 << in.sew;
        n   = XLEN / w;
        m   = (128'd1 << w) - 128'd1;
        res = '0;
        for (int j = 0; j < n; j++) begin
            a  = sext(in.vs1 >> (j * w), w);
            b  = sext(in.vs2 >> (j * w), w);
            d  = sext(in.old_vd >> (j * w), w);
            sh = int'(a[5:0]) & (w - 1);     // Amount modulo SEW
            case (in.op)
                VADD:    e = a + b;
                VSUB:    e = b - a;
                VRSUB:   e = a - b;
                VAND:    e = a & b;
                VOR:     e = a | b;
                VXOR:    e = a ^ b;
                VMUL:    e = a * b;
                VMULH:   e = (a * b) >> w;
                VMULHU:  e = ((a & m) * (b & m)) >> w;
                VMACC:   e = d + a * b;
                VNMSAC:  e = d - a * b;
                VMADD:   e = a * d + b;
                VNMSUB:  e = b - a * d;
                VMIN:    e = ($signed(b) < $signed(a)) ? b : a;
                VMINU:   e = ((b & m) < (a & m)) ? b : a;
                VMAX:    e = ($signed(b) < $signed(a)) ? a : b;
                VMAXU:   e = ((b & m) < (a & m)) ? a : b;
                VMSEQ:   e = 128'(a == b);
                VMSNE:   e = 128'(a != b);
                VMSLT:   e = 128'($signed(b) < $signed(a));
                VMSLTU:  e = 128'((b & m) < (a & m));
                VSLL:    e = b << sh;
                VSRL:    e = (b & m) >> sh;
                VSRA:    e = $signed(b) >>> sh;
                VMV:     e = a;
                VID:     e = 128'(LANE_ID * n + j);
                default: e = '0;
            endcase
            if (in.op inside {VMSEQ, VMSNE, VMSLT, VMSLTU}) begin
                res[j] = e[0];               // One mask bit per element
            end else begin
                res = res | XLEN'((e & m) << (j * w));
            end
        end
        return res;
    endfunction

    function automatic string op_name(vop_t op);
        return op.name();
    endfunction

    assign expected = ref_result(instr_d2);

    a_reset_idle: assert property (@(posedge clk_i) !rstn_i |-> !valid_i)
        else begin
            err_cnt++;
            $error("Fail %0t: valid_o high during reset", $time);
        end

    a_valid: assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_i == instr_d2.valid)
        else begin
            err_cnt++;
            $error("Fail %0t: valid_o is %b, expected %b", $time,
                   $sampled(valid_i), $sampled(instr_d2.valid));
        end

    a_result: assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_i |-> data_i == expected)
        else begin
            err_cnt++;
            $error("Fail %0t: %s gave %h, expected %h", $time,
                   op_name($sampled(instr_d2.op)), $sampled(data_i), $sampled(expected));
        end

endmodule

bind simd_lane_top simd_lane_chk #(
    .LANE_ID (LANE_ID)
) chk (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .instr_i (instr_i),
    .valid_i (valid_o),
    .data_i  (data_vd_o)
);

//--- tests/simd_lane_tb.sv
// SIMD lane testbench
module simd_lane_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import simd_pkg::*;

    localparam int N_DIRECTED = 26 * 4;      // Every opcode at every SEW
    localparam int N_RANDOM   = 400;
    localparam int TIMEOUT_NS = (8 + N_DIRECTED + 2 * N_RANDOM + 10) * 10 + 500;

    logic        clk_i;
    logic        rstn_i;
    lane_instr_t instr_i;
    logic        valid_o;
    bus64_t      data_vd_o;
    logic [31:0] lfsr_q = 32'd74;
    int          n_issued = 0;

    simd_lane_top #(
        .LANE_ID (2)
    ) uut (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .instr_i   (instr_i),
        .valid_o   (valid_o),
        .data_vd_o (data_vd_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Galois LFSR stepped once per bit taken
    function automatic bus64_t rand_bits(int n);
        bus64_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r      = {r[62:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return r;
    endfunction

    // Corner operands with the sign bit set at every SEW in pattern 1
    function automatic bus64_t edge_value(int k);
        case (k % 5)
            0:       return '1;
            1:       return 64'h8080_8080_8080_8080;
            2:       return '0;
            3:       return 64'h00FF_00FF_00FF_00FF;
            default: return 64'h7FFF_FFFF_7FFF_FFFF;
        endcase
    endfunction

    task automatic send(input lane_instr_t ins);
        @(posedge clk_i);
        instr_i <= ins;
        if (ins.valid) begin
            n_issued++;
        end
    endtask

    initial begin
        lane_instr_t ins;
        rstn_i        = 1'b0;
        instr_i       = '0;
        instr_i.valid = 1'b1;                // Valid strobe high while in reset
        repeat (8) @(posedge clk_i);
        rstn_i  <= 1'b1;
        instr_i <= '0;
        for (int k = 0; k < N_DIRECTED; k++) begin
            ins.valid  = 1'b1;
            ins.op     = vop_t'(5'(k / 4));
            ins.sew    = sew_t'(2'(k % 4));
            ins.vs1    = edge_value(k);
            ins.vs2    = edge_value(k + 1);
            ins.old_vd = edge_value(k + 3);
            send(ins);
        end
        for (int k = 0; k < N_RANDOM; k++) begin
            if (rand_bits(3) == 0) begin
                send('0);                    // Idle slot
            end
            ins.valid  = 1'b1;
            ins.op     = vop_t'(5'(rand_bits(5) % 26));
            ins.sew    = sew_t'(2'(rand_bits(2)));
            ins.vs1    = rand_bits(64);
            ins.vs2    = rand_bits(64);
            ins.old_vd = rand_bits(64);
            send(ins);
        end
        send('0);
        repeat (4) @(posedge clk_i);         // Drain the pipeline
        $display("Issued %0d instructions, %0d checker errors", n_issued, uut.chk.err_cnt);
        if (uut.chk.err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule
